// ==== design/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Address of the first instruction fetch
`define CORE_RESET_PC 32'h0000_0000

// Architectural register count, x0 included
`define CORE_NUM_REGS 32

`endif

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Execute controls

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } branch_kind_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch control

    // DISCARD drops the single stale return after a redirect
    typedef enum logic {
        FETCH_RUN,
        FETCH_DISCARD
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             issue_stall,
    input  logic             redirect,
    input  core_pkg::addr_t  redirect_pc,
    output logic             imem_en,
    output core_pkg::addr_t  imem_addr,
    input  core_pkg::word_t  imem_rdata,
    output logic             fetch_valid,
    output core_pkg::addr_t  fetch_pc,
    output core_pkg::word_t  fetch_instr
);
    import core_pkg::*;

    // Next address to request
    addr_t        pc;
    // Word of last cycle's request is on imem_rdata now
    logic         req_valid;
    logic         running;
    fetch_state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // Memory request

    assign imem_en = running;

    // Stalled fetch asks for the same word again so it is still there next cycle
    assign imem_addr = issue_stall ? fetch_pc : pc;

    ////////////////////////////////////////////////////////////////////////////
    // Memory return

    assign fetch_valid = req_valid && (state == FETCH_RUN);
    assign fetch_instr = imem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            req_valid <= 1'b0;
            pc        <= `CORE_RESET_PC;
            state     <= FETCH_RUN;
        end else begin
            running   <= 1'b1;
            req_valid <= running;
            if (redirect) begin
                pc    <= redirect_pc;
                state <= FETCH_DISCARD;
            end else begin
                state <= FETCH_RUN;
                if (running && !issue_stall) begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    // Address of the word coming back next cycle
    always_ff @(posedge clk) begin
        if (running) begin
            fetch_pc <= imem_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions

    // The return in flight during a redirect belongs to the old path
    redirect_drops_return : assert property (
        @(posedge clk) disable iff (!arst_n) redirect |=> !fetch_valid
    ) else $error("fetch_valid high in the cycle after a redirect");

endmodule

`default_nettype wire

// ==== design/decode_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_issue_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   fetch_valid,
    input  core_pkg::addr_t        fetch_pc,
    input  core_pkg::word_t        fetch_instr,
    output logic                   issue_stall,
    input  logic                   redirect,
    output core_pkg::reg_addr_t    rs1_addr,
    output core_pkg::reg_addr_t    rs2_addr,
    input  core_pkg::word_t        rs1_data,
    input  core_pkg::word_t        rs2_data,
    output logic                   ex_valid,
    output core_pkg::addr_t        ex_pc,
    output core_pkg::reg_addr_t    ex_rd,
    output logic                   ex_rd_write,
    output core_pkg::alu_op_t      ex_op,
    output core_pkg::branch_kind_t ex_branch,
    output core_pkg::word_t        ex_a,
    output core_pkg::word_t        ex_b,
    output core_pkg::word_t        ex_rs1_val,
    output core_pkg::word_t        ex_rs2_val,
    output core_pkg::word_t        ex_offset
);
    import core_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    reg_addr_t    rd;
    word_t        imm_i;
    word_t        imm_u;
    word_t        imm_b;
    word_t        imm_j;
    logic         writes;
    logic         use_rs1;
    logic         use_rs2;
    logic         hazard;
    alu_op_t      op;
    branch_kind_t branch;
    word_t        a_val;
    word_t        b_val;
    word_t        offset;

    assign opcode   = fetch_instr[6:0];
    assign rd       = fetch_instr[11:7];
    assign funct3   = fetch_instr[14:12];
    assign rs1_addr = fetch_instr[19:15];
    assign rs2_addr = fetch_instr[24:20];
    assign funct7   = fetch_instr[31:25];

    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
    assign imm_u = {fetch_instr[31:12], 12'b0};
    assign imm_b = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                    fetch_instr[30:25], fetch_instr[11:8], 1'b0};
    assign imm_j = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                    fetch_instr[20], fetch_instr[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Decoder

    // Anything not matched falls out as a no-op without a write
    always_comb begin
        op      = ALU_ADD;
        branch  = BR_NONE;
        writes  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        a_val   = rs1_data;
        b_val   = rs2_data;
        offset  = imm_b;
        case (opcode)
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                b_val   = imm_i;
                writes  = 1'b1;
                case (funct3)
                    3'b000:  op = ALU_ADD;
                    3'b100:  op = ALU_XOR;
                    3'b110:  op = ALU_OR;
                    3'b111:  op = ALU_AND;
                    default: writes = 1'b0;
                endcase
            end
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                writes  = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: op = ALU_ADD;
                    10'b0100000_000: op = ALU_SUB;
                    10'b0000000_100: op = ALU_XOR;
                    10'b0000000_110: op = ALU_OR;
                    10'b0000000_111: op = ALU_AND;
                    default:         writes = 1'b0;
                endcase
            end
            OPC_LUI: begin
                op     = ALU_PASS_B;
                a_val  = '0;
                b_val  = imm_u;
                writes = 1'b1;
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct3 == 3'b000) begin
                    branch = BR_EQ;
                end else if (funct3 == 3'b001) begin
                    branch = BR_NE;
                end
            end
            OPC_JAL: begin
                branch = BR_JAL;
                writes = 1'b1;
                offset = imm_j;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard

    // Only the writer in execute is pending since writeback is bypassed
    assign hazard = ex_valid && ex_rd_write &&
                    ((use_rs1 && rs1_addr == ex_rd) || (use_rs2 && rs2_addr == ex_rd));
    assign issue_stall = fetch_valid && hazard;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= fetch_valid && !issue_stall && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc       <= fetch_pc;
        ex_rd       <= rd;
        ex_rd_write <= writes && (rd != '0);
        ex_op       <= op;
        ex_branch   <= branch;
        ex_a        <= a_val;
        ex_b        <= b_val;
        ex_rs1_val  <= rs1_data;
        ex_rs2_val  <= rs2_data;
        ex_offset   <= offset;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions

    // A stall needs a writer in execute and lasts a single cycle
    stall_needs_writer : assert property (
        @(posedge clk) disable iff (!arst_n) issue_stall |-> ex_valid ##1 !issue_stall
    ) else $error("issue_stall without a writer in execute or longer than one cycle");

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  core_pkg::addr_t        ex_pc,
    input  core_pkg::reg_addr_t    ex_rd,
    input  logic                   ex_rd_write,
    input  core_pkg::alu_op_t      ex_op,
    input  core_pkg::branch_kind_t ex_branch,
    input  core_pkg::word_t        ex_a,
    input  core_pkg::word_t        ex_b,
    input  core_pkg::word_t        ex_rs1_val,
    input  core_pkg::word_t        ex_rs2_val,
    input  core_pkg::word_t        ex_offset,
    output logic                   wb_valid,
    output core_pkg::addr_t        wb_pc,
    output core_pkg::reg_addr_t    wb_rd,
    output logic                   wb_rd_write,
    output core_pkg::word_t        wb_value,
    output logic                   redirect,
    output core_pkg::addr_t        redirect_pc
);
    import core_pkg::*;

    word_t alu_result;
    word_t result;
    logic  taken;

    ////////////////////////////////////////////////////////////////////////////
    // ALU

    always_comb begin
        case (ex_op)
            ALU_ADD:    alu_result = ex_a + ex_b;
            ALU_SUB:    alu_result = ex_a - ex_b;
            ALU_AND:    alu_result = ex_a & ex_b;
            ALU_OR:     alu_result = ex_a | ex_b;
            ALU_XOR:    alu_result = ex_a ^ ex_b;
            ALU_PASS_B: alu_result = ex_b;
            default:    alu_result = '0;
        endcase
    end

    // JAL links the return address
    assign result = (ex_branch == BR_JAL) ? ex_pc + 32'd4 : alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution

    always_comb begin
        case (ex_branch)
            BR_EQ:   taken = (ex_rs1_val == ex_rs2_val);
            BR_NE:   taken = (ex_rs1_val != ex_rs2_val);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = ex_valid && taken;
    assign redirect_pc = ex_pc + ex_offset;

    ////////////////////////////////////////////////////////////////////////////
    // Result register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc       <= ex_pc;
        wb_rd       <= ex_rd;
        wb_rd_write <= ex_rd_write;
        wb_value    <= result;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions

    // Decode must have flushed the wrong-path instruction behind the branch
    redirect_flushes_issue : assert property (
        @(posedge clk) disable iff (!arst_n) redirect |-> ex_valid ##1 !ex_valid
    ) else $error("redirect without a flush of the issue stage");

endmodule

`default_nettype wire

// ==== design/register_file_and_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module register_file_and_writeback (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wb_valid,
    input  core_pkg::addr_t     wb_pc,
    input  core_pkg::reg_addr_t wb_rd,
    input  logic                wb_rd_write,
    input  core_pkg::word_t     wb_value,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    output logic                retire_valid,
    output core_pkg::addr_t     retire_pc,
    output core_pkg::reg_addr_t retire_rd,
    output logic                retire_write,
    output core_pkg::word_t     retire_value
);
    import core_pkg::*;

    // x0 has no storage
    word_t regs [1:`CORE_NUM_REGS-1];
    logic  wr_en;

    assign wr_en = wb_valid && wb_rd_write;

    // Same-cycle write shows through to the reader
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && wb_rd == addr) begin
            value = wb_value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wr_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retire trace

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc    <= wb_pc;
        retire_rd    <= wb_rd;
        retire_write <= wb_rd_write;
        retire_value <= wb_value;
    end

    // Decode clears the write flag for rd x0
    no_x0_write : assert property (
        @(posedge clk) disable iff (!arst_n) wr_en |-> (wb_rd != '0)
    ) else $error("write to x0 reached writeback");

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                clk,
    input  logic                arst_n,
    output logic                imem_en,
    output core_pkg::addr_t     imem_addr,
    input  core_pkg::word_t     imem_rdata,
    output logic                retire_valid,
    output core_pkg::addr_t     retire_pc,
    output core_pkg::reg_addr_t retire_rd,
    output logic                retire_write,
    output core_pkg::word_t     retire_value
);
    import core_pkg::*;

    // Fetch to decode
    logic         fetch_valid;
    addr_t        fetch_pc;
    word_t        fetch_instr;
    logic         issue_stall;

    // Register read ports
    reg_addr_t    rs1_addr;
    reg_addr_t    rs2_addr;
    word_t        rs1_data;
    word_t        rs2_data;

    // Decode to execute
    logic         ex_valid;
    addr_t        ex_pc;
    reg_addr_t    ex_rd;
    logic         ex_rd_write;
    alu_op_t      ex_op;
    branch_kind_t ex_branch;
    word_t        ex_a;
    word_t        ex_b;
    word_t        ex_rs1_val;
    word_t        ex_rs2_val;
    word_t        ex_offset;

    // Execute to writeback and flush
    logic         wb_valid;
    addr_t        wb_pc;
    reg_addr_t    wb_rd;
    logic         wb_rd_write;
    word_t        wb_value;
    logic         redirect;
    addr_t        redirect_pc;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    fetch_stage fetch_stage_block (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Decode and issue
    decode_issue_stage decode_issue_stage_block (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    execute_stage execute_stage_block (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Register file and writeback
    register_file_and_writeback register_file_and_writeback_block (.*);

endmodule

`default_nettype wire

// ==== sim/retire_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_checker (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                retire_valid,
    input  core_pkg::addr_t     retire_pc,
    input  core_pkg::reg_addr_t retire_rd,
    input  logic                retire_write,
    input  core_pkg::word_t     retire_value,
    input  logic [127:0]        exp_name,
    input  core_pkg::addr_t     exp_pc,
    input  core_pkg::reg_addr_t exp_rd,
    input  logic                exp_write,
    input  core_pkg::word_t     exp_value,
    input  int                  row_count,
    output int                  event_count,
    output int                  pass_count,
    output int                  fail_count,
    output int                  error_count
);
    import core_pkg::*;

    int events = 0;
    int passes = 0;
    int fails  = 0;
    int errors = 0;

    assign event_count = events;
    assign pass_count  = passes;
    assign fail_count  = fails;
    assign error_count = errors;

    ////////////////////////////////////////////////////////////////////////////
    // Retire monitor

    // Expected row follows events and moves on at the next edge
    always @(posedge clk) begin
        if (!arst_n) begin
            if (retire_valid) begin
                $display("retire_valid went high while reset was still asserted");
                errors <= errors + 1;
            end
        end else if (retire_valid && events < row_count) begin
            if (retire_pc !== exp_pc) begin
                $display("[ERROR] %0s: retire_pc expected %h, actual %h",
                         exp_name, exp_pc, retire_pc);
                fails <= fails + 1;
            end else if (retire_write !== exp_write) begin
                $display("[ERROR] %0s: retire_write expected %b, actual %b",
                         exp_name, exp_write, retire_write);
                fails <= fails + 1;
            end else if (exp_write && retire_rd !== exp_rd) begin
                $display("[ERROR] %0s: retire_rd expected x%0d, actual x%0d",
                         exp_name, exp_rd, retire_rd);
                fails <= fails + 1;
            end else if (exp_write && retire_value !== exp_value) begin
                $display("[ERROR] %0s: retire_value expected %h, actual %h",
                         exp_name, exp_value, retire_value);
                fails <= fails + 1;
            end else begin
                $display("[PASS] %0s: pc %h", exp_name, retire_pc);
                passes <= passes + 1;
            end
            events <= events + 1;
        end
    end

endmodule

`default_nettype wire

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_tb;
    import core_pkg::*;

    localparam int MAX_ROWS       = 32;
    localparam int RETIRE_TIMEOUT = 200;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      imem_en;
    addr_t     imem_addr;
    word_t     imem_rdata = '0;
    logic      retire_valid;
    addr_t     retire_pc;
    reg_addr_t retire_rd;
    logic      retire_write;
    word_t     retire_value;

    word_t mem [0:63];

    // One expectation row per retire event
    logic [127:0] tbl_name  [0:MAX_ROWS-1];
    addr_t        tbl_pc    [0:MAX_ROWS-1];
    reg_addr_t    tbl_rd    [0:MAX_ROWS-1];
    logic         tbl_write [0:MAX_ROWS-1];
    word_t        tbl_value [0:MAX_ROWS-1];
    int           num_rows;
    addr_t        next_pc;
    logic         timed_out;

    int         event_count;
    int         pass_count;
    int         fail_count;
    int         error_count;
    logic [4:0] cur_row;

    always #4 clk = ~clk;

    // Instruction memory with one-cycle read
    always @(posedge clk) begin
        if (imem_en) begin
            imem_rdata <= mem[imem_addr[7:2]];
        end
    end

    rv_core rv_core_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_en      (imem_en),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_write (retire_write),
        .retire_value (retire_value)
    );

    assign cur_row = event_count[4:0];

    retire_checker retire_checker_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_write (retire_write),
        .retire_value (retire_value),
        .exp_name     (tbl_name[cur_row]),
        .exp_pc       (tbl_pc[cur_row]),
        .exp_rd       (tbl_rd[cur_row]),
        .exp_write    (tbl_write[cur_row]),
        .exp_value    (tbl_value[cur_row]),
        .row_count    (num_rows),
        .event_count  (event_count),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .error_count  (error_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // RV32I encoders

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_lui(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_branch(input logic [12:0] off, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_jal(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program and expectation table

    // Unused words become ADDI x31, x0, index so a stray fetch shows up by its pc
    task automatic fill_memory();
        int i;
        for (i = 0; i < 64; i++) begin
            mem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd31);
        end
    endtask

    task automatic add_row(input logic [127:0] name, input word_t instr,
                           input reg_addr_t rd, input logic write, input word_t value);
        tbl_name[num_rows[4:0]]  = name;
        tbl_pc[num_rows[4:0]]    = next_pc;
        tbl_rd[num_rows[4:0]]    = rd;
        tbl_write[num_rows[4:0]] = write;
        tbl_value[num_rows[4:0]] = value;
        mem[next_pc[7:2]]        = instr;
        num_rows = num_rows + 1;
        next_pc  = next_pc + 32'd4;
    endtask

    // Words jumped over by a taken branch keep the fill pattern
    task automatic skip_words(input int count);
        next_pc = next_pc + 32'(4 * count);
    endtask

    task automatic load_program();
        addr_t link_addr;
        add_row("addi", enc_i(12'd5, 5'd0, 3'b000, 5'd1), 5'd1, 1'b1, 32'h0000_0005);
        add_row("addi_neg", enc_i(12'hffd, 5'd0, 3'b000, 5'd2), 5'd2, 1'b1, 32'hffff_fffd);
        add_row("andi", enc_i(12'h0f0, 5'd2, 3'b111, 5'd3), 5'd3, 1'b1, 32'h0000_00f0);
        add_row("ori", enc_i(12'h100, 5'd1, 3'b110, 5'd4), 5'd4, 1'b1, 32'h0000_0105);
        add_row("xori", enc_i(12'hfff, 5'd2, 3'b100, 5'd5), 5'd5, 1'b1, 32'h0000_0002);
        add_row("lui", enc_lui(20'h12345, 5'd6), 5'd6, 1'b1, 32'h1234_5000);
        add_row("add", enc_r(7'h00, 5'd4, 5'd1, 3'b000, 5'd7), 5'd7, 1'b1, 32'h0000_010a);
        add_row("sub", enc_r(7'h20, 5'd4, 5'd1, 3'b000, 5'd8), 5'd8, 1'b1, 32'hffff_ff00);
        add_row("and", enc_r(7'h00, 5'd2, 5'd6, 3'b111, 5'd9), 5'd9, 1'b1, 32'h1234_5000);
        add_row("or", enc_r(7'h00, 5'd5, 5'd3, 3'b110, 5'd10), 5'd10, 1'b1, 32'h0000_00f2);
        add_row("xor", enc_r(7'h00, 5'd3, 5'd6, 3'b100, 5'd11), 5'd11, 1'b1, 32'h1234_50f0);
        // Back-to-back dependent chain on x12
        add_row("chain_seed", enc_i(12'd1, 5'd0, 3'b000, 5'd12), 5'd12, 1'b1, 32'd1);
        add_row("chain_double1", enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd12),
                5'd12, 1'b1, 32'd2);
        add_row("chain_double2", enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd12),
                5'd12, 1'b1, 32'd4);
        add_row("chain_sub", enc_r(7'h20, 5'd1, 5'd12, 3'b000, 5'd13),
                5'd13, 1'b1, 32'hffff_ffff);
        // x0 ignores the write and reads back as zero
        add_row("x0_write", enc_i(12'h055, 5'd0, 3'b000, 5'd0), 5'd0, 1'b0, 32'd0);
        add_row("x0_read", enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14), 5'd14, 1'b1, 32'd5);
        // Branches
        add_row("beq_not_taken", enc_branch(13'd8, 5'd4, 5'd1, 3'b000), 5'd0, 1'b0, 32'd0);
        add_row("beq_taken", enc_branch(13'd12, 5'd12, 5'd12, 3'b000), 5'd0, 1'b0, 32'd0);
        skip_words(2);
        add_row("bne_not_taken", enc_branch(13'd8, 5'd1, 5'd1, 3'b001), 5'd0, 1'b0, 32'd0);
        add_row("bne_taken", enc_branch(13'd12, 5'd4, 5'd1, 3'b001), 5'd0, 1'b0, 32'd0);
        skip_words(2);
        // JAL links pc+4 and lands two words past it
        link_addr = next_pc + 32'd4;
        add_row("jal", enc_jal(21'd12, 5'd15), 5'd15, 1'b1, link_addr);
        skip_words(2);
        add_row("after_jal", enc_r(7'h00, 5'd0, 5'd15, 3'b000, 5'd16),
                5'd16, 1'b1, link_addr);
        add_row("final", enc_i(12'd1, 5'd16, 3'b000, 5'd17), 5'd17, 1'b1,
                link_addr + 32'd1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence

    task automatic wait_for_retire(input int row);
        int cycles;
        cycles = 0;
        while (event_count <= row && cycles < RETIRE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (event_count <= row) begin
            $display("Timeout: test %0s did not retire within %0d cycles",
                     tbl_name[row[4:0]], RETIRE_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int row;
        arst_n    = 1'b0;
        num_rows  = 0;
        next_pc   = `CORE_RESET_PC;
        timed_out = 1'b0;
        fill_memory();
        load_program();

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        for (row = 0; row < num_rows && !timed_out; row++) begin
            wait_for_retire(row);
        end

        $display("Tests passed: %0d, failed: %0d, other errors: %0d",
                 pass_count, fail_count, error_count);
        if (timed_out || fail_count != 0 || error_count != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/core_pkg.sv
design/fetch_stage.sv
design/decode_issue_stage.sv
design/execute_stage.sv
design/register_file_and_writeback.sv
design/rv_core.sv
sim/retire_checker.sv
sim/core_tb.sv

// ==== Makefile ====
# Verilator simulation of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# Pass or fail is decided only by the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
